// File: bram_selftest_top.f
+incdir+source
source/bram_selftest_pkg.sv
source/bram_port_if.sv
source/reset_stretch.sv
source/selftest_seq.sv
source/pattern_gen.sv
source/sdp_ram.sv
source/readback_check.sv
source/bram_selftest_top.sv
tb/bram_selftest_props.sv
tb/bram_selftest_tb.sv

// File: Bender.yml
package:
  name: bram_selftest

export_include_dirs:
  - source

sources:
  - files:
      - source/bram_selftest_pkg.sv
      - source/bram_port_if.sv
      - source/reset_stretch.sv
      - source/selftest_seq.sv
      - source/pattern_gen.sv
      - source/sdp_ram.sv
      - source/readback_check.sv
      - source/bram_selftest_top.sv
  - target: test
    files:
      - tb/bram_selftest_props.sv
      - tb/bram_selftest_tb.sv

// File: tb/bram_selftest_tb.sv
// Block RAM self-test testbench
`timescale 1ns/1ns
`include "bram_selftest_macros.svh"

module bram_selftest_tb;
	import bram_selftest_pkg::*;

	localparam int CLK_HALF = 2;	// 4 ns period
	localparam int DRIVE_DELAY = 1;	// Inputs change after the rising edge
	localparam int RESET_CYCLES = 10;
	localparam int NUM_RUNS = 27;	// Every start below, the aborted one too
	localparam int WATCHDOG_CYCLES = NUM_RUNS * 40 + 100;
	localparam int START_LIMIT = 8;	// Synchroniser and edge detect, with margin
	localparam int RANDOM_RUNS = 20;

	logic wclk;
	logic rst_n;
	logic pll_locked;
	logic sw0;
	logic sw1;
	logic led0_r;
	logic led0_g;
	logic led0_b;
	logic led1_r;
	logic led1_g;
	logic led1_b;

	// Reference model
	run_tag_t model_tag;	// Bumped on each accepted start
	bram_word_u model_mem [`BRAM_DEPTH];
	logic model_fail;	// LED 1 red expected

	bram_selftest_top bram_selftest_top_i
	(
		.i_wclk (wclk),
		.i_rst_n (rst_n),
		.i_pll_locked (pll_locked),
		.i_sw0 (sw0),
		.i_sw1 (sw1),
		.o_led0_r (led0_r),
		.o_led0_g (led0_g),
		.o_led0_b (led0_b),
		.o_led1_r (led1_r),
		.o_led1_g (led1_g),
		.o_led1_b (led1_b)
	);

	initial
	begin
		wclk = 1'b0;
	end

	always #CLK_HALF wclk = ~wclk;

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// One step, to the point where inputs are driven and outputs are settled
	task automatic tick();
		@(posedge wclk);
		#DRIVE_DELAY;
	endtask

	function automatic test_state_e led0_state();
		return test_state_e'({led0_r, led0_g, led0_b});
	endfunction

	task automatic expect_state(input test_state_e exp, input string where);
		test_state_e act;
		act = led0_state();
		if (act !== exp)
		begin
			$display("FAIL @%0t ns: LED 0 shows %b, expected %s (%s)", $time, act, exp.name(), where);
			stop_with_failure();
		end
	endtask

	task automatic verify_led1(input logic exp_fail, input string where);
		logic [2:0] act;
		logic [2:0] exp;
		act = {led1_r, led1_g, led1_b};
		exp = exp_fail ? 3'b100 : 3'b001;	// Red on fail, blue on pass
		if (act !== exp)
		begin
			$display("FAIL @%0t ns: LED 1 rgb %b, expected %b (%s)", $time, act, exp, where);
			stop_with_failure();
		end
	endtask

	task automatic expect_count(input string what, input int act, input int exp);
		if (act != exp)
		begin
			$display("FAIL @%0t ns: %s is %0d, expected %0d", $time, what, act, exp);
			stop_with_failure();
		end
	endtask

	// Write phase as the model sees it
	function automatic void model_write(input logic inject);
		int a;
		logic [`BRAM_DATA_W/2-1:0] pat;
		for (a = 0; a < `BRAM_DEPTH; a++)
		begin
			pat = {model_tag, bram_addr_t'(a)};	// Tag above the address
			model_mem[a].fields.lo = pat;
			model_mem[a].fields.hi_inv = ~pat ^ {{(`BRAM_DATA_W/2-1){1'b0}}, inject};
		end
	endfunction

	function automatic logic model_expect_fail();
		int a;
		logic bad;
		logic [`BRAM_DATA_W/2-1:0] pat;
		bad = 1'b0;
		for (a = 0; a < `BRAM_DEPTH; a++)
		begin
			pat = {model_tag, bram_addr_t'(a)};
			if (model_mem[a].fields.lo !== pat)
				bad = 1'b1;
			if (model_mem[a].fields.hi_inv !== ~model_mem[a].fields.lo)
				bad = 1'b1;	// Halves disagree
		end
		return bad;
	endfunction

	task automatic hold_idle(input int n, input string where);
		repeat (n)
		begin
			tick();
			expect_state(IDLE, where);
			verify_led1(1'b0, where);
		end
	endtask

	// External reset, then the stretch after lock
	task automatic apply_reset();
		rst_n = 1'b0;
		sw0 = 1'b0;
		hold_idle(RESET_CYCLES, "reset held");
		rst_n = 1'b1;
		hold_idle(`SYNC_STAGES + `RST_HOLD_CYCLES + 2, "reset stretch");
		model_tag = '0;
		model_fail = 1'b0;
	endtask

	task automatic begin_run(input logic inject);
		int waited;
		sw1 = inject;	// Held until the next run
		sw0 = 1'b1;
		waited = 0;
		while (led0_state() != WRITE)
		begin
			if (waited == START_LIMIT)
			begin
				$display("Rising edge on sw0 was not accepted within %0d cycles", START_LIMIT);
				stop_with_failure();
			end
			tick();
			waited++;
		end
		sw0 = 1'b0;
		model_tag = model_tag + 1'b1;
		verify_led1(1'b0, "first write cycle");	// Start clears the old result
	endtask

	// Extra sw0 edges land well inside a phase and must be dropped
	task automatic finish_run(input logic inject, input bit extra_edges);
		int wr_cycles;
		int rd_cycles;
		wr_cycles = 0;
		while (led0_state() == WRITE && wr_cycles < 4 * `BRAM_DEPTH)
		begin
			wr_cycles++;
			if (extra_edges && wr_cycles == 3)
				sw0 = 1'b1;
			if (extra_edges && wr_cycles == 5)
				sw0 = 1'b0;
			tick();
		end
		expect_count("write phase length", wr_cycles, `BRAM_DEPTH);
		expect_state(READ, "after write phase");
		model_write(inject);
		rd_cycles = 0;
		while (led0_state() == READ && rd_cycles < 4 * `BRAM_DEPTH)
		begin
			rd_cycles++;
			if (extra_edges && rd_cycles == 1)
				sw0 = 1'b1;
			if (extra_edges && rd_cycles == 3)
				sw0 = 1'b0;
			tick();
		end
		// Eight strobes, then one cycle for the last compare
		expect_count("read phase length", rd_cycles, `BRAM_DEPTH + 1);
		expect_state(DONE, "after read phase");
		model_fail = model_expect_fail();
		verify_led1(model_fail, "end of run");
	endtask

	task automatic idle_gap(input int n);
		repeat (n)
		begin
			tick();
			expect_state(DONE, "between runs");
			verify_led1(model_fail, "between runs");	// Result holds
		end
	endtask

	initial
	begin : stimulus
		int seed_ret;
		int gap;
		int cut;
		logic inject;
		seed_ret = $urandom(32'h2c6b21e1);
		rst_n = 1'b0;
		pll_locked = 1'b1;
		sw0 = 1'b0;
		sw1 = 1'b0;
		model_tag = '0;
		model_fail = 1'b0;
		apply_reset();
		hold_idle(20, "idle after reset");
		// Clean run
		begin_run(1'b0);
		finish_run(1'b0, 1'b0);
		idle_gap(4);
		// Faulty run, then back to blue
		begin_run(1'b1);
		finish_run(1'b1, 1'b0);
		idle_gap(4);
		begin_run(1'b0);
		finish_run(1'b0, 1'b0);
		idle_gap(4);
		// Starts during a run are ignored
		begin_run(1'b0);
		finish_run(1'b0, 1'b1);
		idle_gap(6);
		begin_run(1'b1);
		finish_run(1'b1, 1'b1);
		idle_gap(6);
		for (int i = 0; i < RANDOM_RUNS; i++)
		begin
			inject = logic'($urandom % 2);
			gap = 2 + $urandom % 8;
			begin_run(inject);
			finish_run(inject, 1'b0);
			idle_gap(gap);
		end
		// Reset cuts a run short
		inject = logic'($urandom % 2);
		cut = 1 + $urandom % 12;
		begin_run(inject);
		repeat (cut) tick();
		apply_reset();
		begin_run(1'b0);
		finish_run(1'b0, 1'b0);
		idle_gap(4);
		// Strobe and LED properties from the bound checker
		if (bram_selftest_top_i.bram_selftest_props_i.fail_count != 0)
		begin
			$display("Bound assertions failed %0d times",
				bram_selftest_top_i.bram_selftest_props_i.fail_count);
			stop_with_failure();
		end
		else
		begin
			$display("TEST PASSED");
			$finish;
		end
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge wclk);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		stop_with_failure();
	end

endmodule

// File: tb/bram_selftest_props.sv
// Self-test strobe and LED assertions
`timescale 1ns/1ns

module bram_selftest_props
(
	input logic i_wclk,
	input logic i_rst_n,	// Stretched test reset
	input logic i_we,
	input logic i_re,
	input bram_selftest_pkg::test_state_e i_state,
	input logic i_led1_r,
	input logic i_led1_b
);
	import bram_selftest_pkg::*;

	int unsigned fail_count = 0;	// Assertion failures seen so far

	// Phases never overlap
	strobes_apart: assert property (@(posedge i_wclk) disable iff (!i_rst_n) !(i_we && i_re))
	else
	begin
		$error("write and read strobes high in the same cycle");
		fail_count++;
	end

	we_in_write: assert property (@(posedge i_wclk) disable iff (!i_rst_n)
		i_we |-> i_state == WRITE)
	else
	begin
		$error("write strobe outside the write phase");
		fail_count++;
	end

	re_in_read: assert property (@(posedge i_wclk) disable iff (!i_rst_n)
		i_re |-> i_state == READ)
	else
	begin
		$error("read strobe outside the read phase");
		fail_count++;
	end

	// Pass or fail, never both or neither
	led1_one_colour: assert property (@(posedge i_wclk) disable iff (!i_rst_n)
		i_led1_r ^ i_led1_b)
	else
	begin
		$error("LED 1 does not show exactly one of red and blue");
		fail_count++;
	end

endmodule

bind bram_selftest_top bram_selftest_props bram_selftest_props_i
(
	.i_wclk (i_wclk),
	.i_rst_n (test_rst_n),
	.i_we (bram_port.we),
	.i_re (bram_port.re),
	.i_state (state),
	.i_led1_r (o_led1_r),
	.i_led1_b (o_led1_b)
);

// File: source/bram_selftest_top.sv
// Block RAM self-test top
`timescale 1ns/1ns

module bram_selftest_top
(
	input logic i_wclk,
	input logic i_rst_n,
	input logic i_pll_locked,
	input logic i_sw0,	// Start a run
	input logic i_sw1,	// Inject a write fault
	output logic o_led0_r,
	output logic o_led0_g,
	output logic o_led0_b,
	output logic o_led1_r,
	output logic o_led1_g,
	output logic o_led1_b
);
	import bram_selftest_pkg::*;

	logic test_rst_n;	// Held low until lock has settled
	logic wr_phase;
	logic rd_phase;
	logic start;
	logic inject;
	logic last;
	logic fail;
	run_tag_t run_tag;
	test_state_e state;

	bram_port_if bram_port();

	reset_stretch reset_stretch_i
	(
		.i_wclk (i_wclk),
		.i_rst_n (i_rst_n),
		.i_pll_locked (i_pll_locked),
		.o_test_rst_n (test_rst_n)
	);

	selftest_seq selftest_seq_i
	(
		.i_wclk (i_wclk),
		.i_rst_n (test_rst_n),
		.i_sw0 (i_sw0),
		.i_sw1 (i_sw1),
		.i_last (last),
		.o_wr_phase (wr_phase),
		.o_rd_phase (rd_phase),
		.o_start (start),
		.o_inject (inject),
		.o_run_tag (run_tag),
		.o_state (state)
	);

	pattern_gen pattern_gen_i
	(
		.i_wclk (i_wclk),
		.i_rst_n (test_rst_n),
		.i_wr_phase (wr_phase),
		.i_rd_phase (rd_phase),
		.i_start (start),
		.i_inject (inject),
		.i_run_tag (run_tag),
		.o_last (last),
		.mem_if (bram_port)
	);

	sdp_ram sdp_ram_i
	(
		.i_wclk (i_wclk),
		.i_rst_n (test_rst_n),
		.mem_if (bram_port)
	);

	readback_check readback_check_i
	(
		.i_wclk (i_wclk),
		.i_rst_n (test_rst_n),
		.i_start (start),
		.i_run_tag (run_tag),
		.o_fail (fail),
		.mem_if (bram_port)
	);

	// State code drives LED 0 directly
	assign {o_led0_r, o_led0_g, o_led0_b} = state;

	// Red on fail, blue on pass
	assign {o_led1_r, o_led1_g, o_led1_b} = fail ? 3'b100 : 3'b001;

endmodule

// File: source/readback_check.sv
// Read-back checker
`timescale 1ns/1ns

module readback_check
(
	input logic i_wclk,
	input logic i_rst_n,
	input logic i_start,	// Clears the result
	input bram_selftest_pkg::run_tag_t i_run_tag,
	output logic o_fail,	// Sticky until next start
	bram_port_if.chk mem_if
);
	import bram_selftest_pkg::*;

	logic re_q;	// rdata valid this cycle
	bram_addr_t raddr_q;	// Address that rdata came from
	bram_word_u rd_word;
	logic lo_ok;
	logic inv_ok;
	logic mismatch;

	// Line the request up with the returned word
	always_ff @(posedge i_wclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			re_q <= 1'b0;
		else
			re_q <= mem_if.re;
	end

	always_ff @(posedge i_wclk)
	begin
		raddr_q <= mem_if.raddr;
	end

	assign rd_word = mem_if.rdata;
	assign lo_ok = (rd_word.fields.lo == pattern_byte(i_run_tag, raddr_q));
	assign inv_ok = (rd_word.fields.hi_inv == ~rd_word.fields.lo);	// Both halves must agree
	assign mismatch = re_q & ~(lo_ok & inv_ok);

	always_ff @(posedge i_wclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_fail <= 1'b0;
		else if (i_start)
			o_fail <= 1'b0;
		else if (mismatch)
			o_fail <= 1'b1;	// One bad word fails the run
	end

endmodule

// File: source/sdp_ram.sv
// Simple dual-port RAM, read-first
`timescale 1ns/1ns
`include "bram_selftest_macros.svh"

module sdp_ram
(
	input logic i_wclk,
	input logic i_rst_n,	// Clears the read register only
	bram_port_if.ram mem_if
);

	logic [`BRAM_DATA_W-1:0] mem [`BRAM_DEPTH];	// Storage array

	// Write port
	always_ff @(posedge i_wclk)
	begin
		if (mem_if.we)
			mem[mem_if.waddr] <= mem_if.wdata.raw;
	end

	// Read port with no output pipeline
	// Same-address write in this cycle is not seen, old word comes out
	always_ff @(posedge i_wclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			mem_if.rdata.raw <= '0;
		else if (mem_if.re)
			mem_if.rdata.raw <= mem[mem_if.raddr];	// Valid one cycle after re
	end

endmodule

// File: source/pattern_gen.sv
// Write and read pattern generator
`timescale 1ns/1ns
`include "bram_selftest_macros.svh"

module pattern_gen
(
	input logic i_wclk,
	input logic i_rst_n,
	input logic i_wr_phase,
	input logic i_rd_phase,
	input logic i_start,	// Start of a run
	input logic i_inject,	// Corrupt the inverse byte
	input bram_selftest_pkg::run_tag_t i_run_tag,
	output logic o_last,
	bram_port_if.gen mem_if
);
	import bram_selftest_pkg::*;

	localparam bram_addr_t LAST_ADDR = bram_addr_t'(`BRAM_DEPTH - 1);

	bram_addr_t addr_q;	// Shared by both phases
	logic active;
	bram_word_u word;	// Word for the current address

	assign active = i_wr_phase | i_rd_phase;
	assign o_last = active & (addr_q == LAST_ADDR);

	always_ff @(posedge i_wclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			addr_q <= '0;
		else if (i_start | o_last)
			addr_q <= '0;	// Next phase begins at address 0
		else if (active)
			addr_q <= addr_q + 1'b1;
	end

	always_comb
	begin
		word.fields.lo = pattern_byte(i_run_tag, addr_q);
		word.fields.hi_inv = ~word.fields.lo;
		word.fields.hi_inv[0] = word.fields.hi_inv[0] ^ i_inject;	// Checker must catch this
	end

	// One access per cycle in the active phase
	assign mem_if.we = i_wr_phase;
	assign mem_if.waddr = addr_q;
	assign mem_if.wdata = word;
	assign mem_if.re = i_rd_phase;
	assign mem_if.raddr = addr_q;

endmodule

// File: source/selftest_seq.sv
// Self-test sequencer
`timescale 1ns/1ns
`include "bram_selftest_macros.svh"

module selftest_seq
(
	input logic i_wclk,
	input logic i_rst_n,	// Stretched test reset
	input logic i_sw0,	// Start switch
	input logic i_sw1,	// Fault switch
	input logic i_last,	// Eighth address of a phase
	output logic o_wr_phase,
	output logic o_rd_phase,
	output logic o_start,
	output logic o_inject,
	output bram_selftest_pkg::run_tag_t o_run_tag,
	output bram_selftest_pkg::test_state_e o_state
);
	import bram_selftest_pkg::*;

	logic [`SYNC_STAGES-1:0][1:0] sw_pipe;	// Both switches side by side
	logic [1:0] sw_s;	// {sw1, sw0} after synchronising
	logic sw0_prev;
	logic start_edge;
	logic drain_q;	// Last read still in flight
	test_state_e state_q;
	test_state_e state_d;
	run_tag_t run_tag_q;

	assign sw_s = sw_pipe[`SYNC_STAGES-1];
	assign start_edge = sw_s[0] & ~sw0_prev;

	// Edges during a run are dropped here
	assign o_start = start_edge & ((state_q == IDLE) | (state_q == DONE));

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE, DONE:
				if (start_edge)
					state_d = WRITE;
			WRITE:
				if (i_last)
					state_d = READ;
			READ:
				if (drain_q)
					state_d = DONE;	// Final compare has landed in the checker
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge i_wclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			sw_pipe <= '0;
			sw0_prev <= 1'b0;
			state_q <= IDLE;
			drain_q <= 1'b0;
			run_tag_q <= '0;
		end
		else
		begin
			sw_pipe <= {sw_pipe[`SYNC_STAGES-2:0], {i_sw1, i_sw0}};
			sw0_prev <= sw_s[0];
			state_q <= state_d;
			drain_q <= (state_q == READ) & i_last & ~drain_q;	// One spare cycle after last read
			if (o_start)
				run_tag_q <= run_tag_q + 1'b1;	// New pattern every run
		end
	end

	assign o_wr_phase = (state_q == WRITE);
	assign o_rd_phase = (state_q == READ) & ~drain_q;	// Eight strobes, not the spare cycle
	assign o_inject = (state_q == WRITE) & sw_s[1];	// Fault switch only counts while writing
	assign o_run_tag = run_tag_q;
	assign o_state = state_q;

endmodule

// File: source/reset_stretch.sv
// Test reset stretcher
`timescale 1ns/1ns
`include "bram_selftest_macros.svh"

module reset_stretch
(
	input logic i_wclk,
	input logic i_rst_n,
	input logic i_pll_locked,
	output logic o_test_rst_n
);

	localparam int unsigned CNT_W = $clog2(`RST_HOLD_CYCLES + 1);

	logic [`SYNC_STAGES-1:0] lock_pipe;	// Lock comes from another domain
	logic lock_s;
	logic [CNT_W-1:0] cnt_q;	// Cycles since lock
	logic done_q;	// Stretch finished

	assign lock_s = lock_pipe[`SYNC_STAGES-1];

	always_ff @(posedge i_wclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			lock_pipe <= '0;
			cnt_q <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			lock_pipe <= {lock_pipe[`SYNC_STAGES-2:0], i_pll_locked};
			if (!lock_s)
			begin
				// Losing lock starts the count over
				cnt_q <= '0;
				done_q <= 1'b0;
			end
			else if (!done_q)
			begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == CNT_W'(`RST_HOLD_CYCLES - 1))
					done_q <= 1'b1;	// Release on the hold-th cycle of lock
			end
		end
	end

	assign o_test_rst_n = done_q;

endmodule

// File: source/bram_port_if.sv
// RAM port bundle
`timescale 1ns/1ns

interface bram_port_if;
	import bram_selftest_pkg::*;

	// Write side
	logic we;	// One word per strobe
	bram_addr_t waddr;
	bram_word_u wdata;

	// Read side
	logic re;	// rdata follows one cycle later
	bram_addr_t raddr;
	bram_word_u rdata;

	// Pattern generator issues both strobes
	modport gen (output we, waddr, wdata, re, raddr);

	// Memory answers reads
	modport ram (input we, waddr, wdata, re, raddr, output rdata);

	// Checker watches the read side only
	modport chk (input re, raddr, rdata);

endinterface

// File: source/bram_selftest_pkg.sv
// Block RAM self-test types
`include "bram_selftest_macros.svh"

package bram_selftest_pkg;

	typedef logic [`BRAM_ADDR_W-1:0] bram_addr_t;	// One RAM address
	typedef logic [`RUN_TAG_W-1:0] run_tag_t;	// Counts accepted starts

	// Stored word split into its two bytes
	typedef struct packed
	{
		logic [`BRAM_DATA_W/2-1:0] hi_inv;	// Inverse of lo
		logic [`BRAM_DATA_W/2-1:0] lo;	// Pattern byte
	} bram_fields_t;

	// RAM sees raw bits, generator and checker see the two bytes
	typedef union packed
	{
		logic [`BRAM_DATA_W-1:0] raw;
		bram_fields_t fields;
	} bram_word_u;

	// Codes go straight onto the RGB pins of LED 0
	typedef enum logic [2:0]
	{
		IDLE = 3'b000,	// All off
		WRITE = 3'b001,	// Blue
		READ = 3'b010,	// Green
		DONE = 3'b100	// Red
	} test_state_e;

	// Low byte of a word is the run tag above the address
	function automatic logic [`BRAM_DATA_W/2-1:0] pattern_byte(run_tag_t tag, bram_addr_t addr);
		return {tag, addr};
	endfunction

endpackage

// File: source/bram_selftest_macros.svh
// Block RAM self-test sizes
`ifndef BRAM_SELFTEST_MACROS_SVH
`define BRAM_SELFTEST_MACROS_SVH

// RAM geometry
`define BRAM_ADDR_W 3	// Address bits
`define BRAM_DEPTH 8	// Words in the RAM
`define BRAM_DATA_W 16	// Pattern byte plus its inverse

// Reset stretch after PLL lock
`define RST_HOLD_CYCLES 10

// Switch and lock synchroniser depth
`define SYNC_STAGES 2

// Run counter width, upper bits of the pattern byte
`define RUN_TAG_W 5

`endif
